// File: rvPkg.sv
// Shared widths, opcodes, control encodings and bundles for the RV64I core; referenced by scope.
package rvPkg;

    //////////////////////////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////////////////////////
    localparam int xlen         = 64;
    localparam int regAddrW     = 5;
    localparam int memDepthLog2 = 8;
    localparam int memDepth     = 1 << memDepthLog2;            // doublewords.

    localparam logic [xlen-1:0] resetPc   = '0;
    localparam logic [xlen-1:0] instBytes = 64'd4;              // sequential step.

    // major opcodes, inst[6:0]
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    //////////////////////////////////////////////////////////////////////
    // control encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluPassB
    } aluOpT;

    // blt/bge also carry bltu/bgeu, the alu op decides signedness.
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brBeq  = 3'b100,
        brBne  = 3'b101,
        brBlt  = 3'b110,
        brBge  = 3'b111
    } branchT;

    // nine operations, so four bits.
    typedef enum logic [3:0] {
        memNone, memLd, memLw, memLwu, memLb, memLbu, memSd, memSw, memSb
    } memOpT;

    typedef enum logic [1:0] {srcBReg, srcBImm, srcBFour} srcBT;

    typedef struct packed {
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic                regWen;
        logic                srcAIsReg;    // 0 selects pc.
        srcBT                srcB;
        aluOpT               aluOp;
        branchT              branch;
        memOpT               memOp;
        logic                memToReg;
    } ctrlT;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic                rdWen;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     rdData;
        logic                memWen;
        logic [xlen-1:0]     memAddr;
        logic [xlen-1:0]     memData;
    } retireT;

endpackage

// File: alu.sv
// Sixty-four bit integer ALU for the execute stage, result plus zero flag.
`timescale 1ns/100ps

module alu (
    input  logic [rvPkg::xlen-1:0]  inputA,
    input  logic [rvPkg::xlen-1:0]  inputB,
    input  rvPkg::aluOpT            aluOp,
    output logic [rvPkg::xlen-1:0]  result,
    output logic                    zero
);

    logic [5:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = inputB[5:0];                             // rv64 shifts use six bits.
    assign ltSigned   = $signed(inputA) < $signed(inputB);
    assign ltUnsigned = inputA < inputB;

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:   result = inputA + inputB;
            rvPkg::aluSub:   result = inputA - inputB;
            rvPkg::aluAnd:   result = inputA & inputB;
            rvPkg::aluOr:    result = inputA | inputB;
            rvPkg::aluXor:   result = inputA ^ inputB;
            rvPkg::aluSlt:   result = {{(rvPkg::xlen-1){1'b0}}, ltSigned};
            rvPkg::aluSltu:  result = {{(rvPkg::xlen-1){1'b0}}, ltUnsigned};
            rvPkg::aluSll:   result = inputA << shamt;
            rvPkg::aluSrl:   result = inputA >> shamt;
            rvPkg::aluSra:   result = $signed(inputA) >>> shamt;
            rvPkg::aluPassB: result = inputB;                    // lui.
            default:         result = '0;
        endcase
    end

    assign zero = (result == '0);                                // beq/bne after sub.

endmodule

// File: regFile.sv
// Thirty-two entry integer register file, two combinational reads and one clocked write.
`timescale 1ns/100ps

module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [rvPkg::regAddrW-1:0]  raAddr,
    input  logic [rvPkg::regAddrW-1:0]  rbAddr,
    output logic [rvPkg::xlen-1:0]      raData,
    output logic [rvPkg::xlen-1:0]      rbData,
    input  logic [rvPkg::regAddrW-1:0]  wAddr,
    input  logic [rvPkg::xlen-1:0]      wData,
    input  logic                        wen
);

    logic [rvPkg::xlen-1:0] regs [1 << rvPkg::regAddrW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wen) begin
            regs[wAddr] <= wData;                                // visible to the next instruction.
        end
    end

    // x0 reads as zero regardless of contents.
    assign raData = (raAddr == '0) ? '0 : regs[raAddr];
    assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

    // the execute stage must drop writes to x0 before they get here.
    noWriteX0: assert property (@(posedge clk) disable iff (!rstN) wen |-> (wAddr != '0))
        else $error("register write aimed at x0");

endmodule

// File: dataMem.sv
// Doubleword data memory with sized loads and lane stores; addresses are aligned down.
`timescale 1ns/100ps

module dataMem (
    input  logic                    clk,
    input  logic                    rstN,
    input  rvPkg::memOpT            memOp,
    input  logic [rvPkg::xlen-1:0]  addr,
    input  logic [rvPkg::xlen-1:0]  wData,
    output logic [rvPkg::xlen-1:0]  rData
);

    logic [rvPkg::xlen-1:0]         mem [rvPkg::memDepth];
    logic [rvPkg::memDepthLog2-1:0] idx;
    logic [rvPkg::xlen-1:0]         word;
    logic [31:0]                    half;
    logic [7:0]                     byteLane;

    initial begin
        for (int i = 0; i < rvPkg::memDepth; i++) begin
            mem[i] = '0;
        end
    end

    assign idx      = addr[rvPkg::memDepthLog2+2:3];             // wraps modulo depth.
    assign word     = mem[idx];
    assign half     = word[{addr[2], 5'b00000} +: 32];
    assign byteLane = word[{addr[2:0], 3'b000} +: 8];

    //////////////////////////////////////////////////////////////////////
    // load extract and extend
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (memOp)
            rvPkg::memLd:  rData = word;
            rvPkg::memLw:  rData = {{(rvPkg::xlen-32){half[31]}}, half};
            rvPkg::memLwu: rData = {{(rvPkg::xlen-32){1'b0}}, half};
            rvPkg::memLb:  rData = {{(rvPkg::xlen-8){byteLane[7]}}, byteLane};
            rvPkg::memLbu: rData = {{(rvPkg::xlen-8){1'b0}}, byteLane};
            default:       rData = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stores touch only their own lane
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rstN) begin
            case (memOp)
                rvPkg::memSd: mem[idx] <= wData;
                rvPkg::memSw: mem[idx][{addr[2], 5'b00000} +: 32] <= wData[31:0];
                rvPkg::memSb: mem[idx][{addr[2:0], 3'b000} +: 8] <= wData[7:0];
                default: ;
            endcase
        end
    end

endmodule

// File: nextPc.sv
// Next-address logic: picks base and offset from the branch code, then adds them.
`timescale 1ns/100ps

module nextPc (
    input  rvPkg::branchT           branch,
    input  logic                    zero,
    input  logic                    res0,
    input  logic [rvPkg::xlen-1:0]  pc,
    input  logic [rvPkg::xlen-1:0]  imm,
    input  logic [rvPkg::xlen-1:0]  busA,
    output logic [rvPkg::xlen-1:0]  dnpc
);

    logic                   baseIsA;                             // 0 pc, 1 busA.
    logic                   offIsImm;                            // 0 four, 1 imm.
    logic [rvPkg::xlen-1:0] sum;

    always_comb begin
        baseIsA  = 1'b0;
        offIsImm = 1'b0;
        case (branch)
            rvPkg::brJal:  offIsImm = 1'b1;
            rvPkg::brJalr: begin
                baseIsA  = 1'b1;
                offIsImm = 1'b1;
            end
            rvPkg::brBeq:  offIsImm = zero;
            rvPkg::brBne:  offIsImm = ~zero;
            rvPkg::brBlt:  offIsImm = res0;                      // slt/sltu said less.
            rvPkg::brBge:  offIsImm = zero | ~res0;
            default: ;
        endcase
    end

    assign sum  = (baseIsA ? busA : pc) + (offIsImm ? imm : rvPkg::instBytes);
    assign dnpc = {sum[rvPkg::xlen-1:1], 1'b0};                  // jalr drops bit 0.

endmodule

// File: exeUnit.sv
// Execute stage: operand and write-back selects around the register file, ALU and memory.
`timescale 1ns/100ps

module exeUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  rvPkg::ctrlT             ctrl,
    input  logic [rvPkg::xlen-1:0]  pc,
    input  logic [rvPkg::xlen-1:0]  imm,
    output logic [rvPkg::xlen-1:0]  dnpc,
    output logic [rvPkg::xlen-1:0]  wbData,
    output logic [rvPkg::xlen-1:0]  storeAddr,
    output logic [rvPkg::xlen-1:0]  storeData
);

    logic [rvPkg::xlen-1:0] busA, busB;
    logic [rvPkg::xlen-1:0] aluA, aluB, aluRes;
    logic [rvPkg::xlen-1:0] memData;
    logic                   aluZero;
    logic                   regWen;

    assign regWen = ctrl.regWen & rstN & (ctrl.rd != '0);

    assign aluA = ctrl.srcAIsReg ? busA : pc;

    always_comb begin
        case (ctrl.srcB)
            rvPkg::srcBImm:  aluB = imm;
            rvPkg::srcBFour: aluB = rvPkg::instBytes;            // link address for jumps.
            default:         aluB = busB;
        endcase
    end

    assign wbData    = ctrl.memToReg ? memData : aluRes;
    assign storeAddr = aluRes;
    assign storeData = busB;

    regFile u_regFile (
        .clk(clk), .rstN(rstN),
        .raAddr(ctrl.rs1), .rbAddr(ctrl.rs2),
        .raData(busA), .rbData(busB),
        .wAddr(ctrl.rd), .wData(wbData), .wen(regWen)
    );

    alu u_alu (.inputA(aluA), .inputB(aluB), .aluOp(ctrl.aluOp), .result(aluRes), .zero(aluZero));

    dataMem u_dataMem (
        .clk(clk), .rstN(rstN), .memOp(ctrl.memOp),
        .addr(aluRes), .wData(busB), .rData(memData)
    );

    nextPc u_nextPc (
        .branch(ctrl.branch), .zero(aluZero), .res0(aluRes[0]),
        .pc(pc), .imm(imm), .busA(busA), .dnpc(dnpc)
    );

    // every target the pc register will load stays halfword aligned.
    dnpcAligned: assert property (@(posedge clk) disable iff (!rstN) dnpc[0] == 1'b0)
        else $error("next pc has bit 0 set");

endmodule

// File: instDecode.sv
// Combinational decoder from a 32-bit RV64I word to the execute control bundle and immediate.
`timescale 1ns/100ps

module instDecode (
    input  logic [31:0]             inst,
    output rvPkg::ctrlT             ctrl,
    output logic [rvPkg::xlen-1:0]  imm
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [rvPkg::xlen-1:0] immI, immS, immB, immU, immJ;
    rvPkg::ctrlT            c;
    logic                   legal;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{(rvPkg::xlen-12){inst[31]}}, inst[31:20]};
    assign immS = {{(rvPkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(rvPkg::xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};
    assign immU = {{(rvPkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(rvPkg::xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

    // shared by OP and OP-IMM, alt picks sub/sra.
    function automatic rvPkg::aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  return rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b011:  return rvPkg::aluSltu;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return alt ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  return rvPkg::aluOr;
            default: return rvPkg::aluAnd;
        endcase
    endfunction

    always_comb begin
        c           = '0;                                        // enum zeros are the no-op codes.
        c.rd        = inst[11:7];
        c.rs1       = inst[19:15];
        c.rs2       = inst[24:20];
        c.srcAIsReg = 1'b1;
        legal       = 1'b1;
        imm         = immI;
        case (opcode)
            rvPkg::opLui: begin
                c.regWen = 1'b1; c.srcB = rvPkg::srcBImm; c.aluOp = rvPkg::aluPassB;
                imm = immU;
            end
            rvPkg::opAuipc: begin
                c.regWen = 1'b1; c.srcAIsReg = 1'b0; c.srcB = rvPkg::srcBImm;
                imm = immU;
            end
            rvPkg::opJal: begin                                  // link is pc + 4.
                c.regWen = 1'b1; c.srcAIsReg = 1'b0; c.srcB = rvPkg::srcBFour;
                c.branch = rvPkg::brJal;
                imm = immJ;
            end
            rvPkg::opJalr: begin
                c.regWen = 1'b1; c.srcAIsReg = 1'b0; c.srcB = rvPkg::srcBFour;
                c.branch = rvPkg::brJalr;
                legal = (funct3 == 3'b000);
            end
            rvPkg::opBranch: begin
                imm = immB;
                if (!funct3[2]) begin                            // beq, bne.
                    c.aluOp  = rvPkg::aluSub;
                    c.branch = funct3[0] ? rvPkg::brBne : rvPkg::brBeq;
                end else begin
                    c.aluOp  = funct3[1] ? rvPkg::aluSltu : rvPkg::aluSlt;
                    c.branch = funct3[0] ? rvPkg::brBge : rvPkg::brBlt;
                end
                legal = (funct3[2:1] != 2'b01);
            end
            rvPkg::opLoad: begin
                c.regWen = 1'b1; c.srcB = rvPkg::srcBImm; c.memToReg = 1'b1;
                case (funct3)
                    3'b011:  c.memOp = rvPkg::memLd;
                    3'b010:  c.memOp = rvPkg::memLw;
                    3'b110:  c.memOp = rvPkg::memLwu;
                    3'b000:  c.memOp = rvPkg::memLb;
                    3'b100:  c.memOp = rvPkg::memLbu;
                    default: legal = 1'b0;                       // lh/lhu not supported.
                endcase
            end
            rvPkg::opStore: begin
                c.srcB = rvPkg::srcBImm;
                imm = immS;
                case (funct3)
                    3'b011:  c.memOp = rvPkg::memSd;
                    3'b010:  c.memOp = rvPkg::memSw;
                    3'b000:  c.memOp = rvPkg::memSb;
                    default: legal = 1'b0;
                endcase
            end
            rvPkg::opImm: begin
                c.regWen = 1'b1; c.srcB = rvPkg::srcBImm;
                c.aluOp = aluFromF3(funct3, funct3 == 3'b101 && inst[30]);
                if (funct3 == 3'b001)
                    legal = (inst[31:26] == 6'b000000);
                else if (funct3 == 3'b101)
                    legal = (inst[31:26] == 6'b000000) || (inst[31:26] == 6'b010000);
            end
            rvPkg::opReg: begin
                c.regWen = 1'b1;
                c.aluOp = aluFromF3(funct3, inst[30]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin                                        // retire as a plain pc + 4.
            c.regWen = 1'b0;
            c.branch = rvPkg::brNone;
            c.memOp  = rvPkg::memNone;
        end
        ctrl = c;
    end

endmodule

// File: rvCore.sv
// Single-cycle RV64I core top: pc register, decoder, execute stage and the retire record.
`timescale 1ns/100ps

module rvCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [31:0]             inst,
    output logic [rvPkg::xlen-1:0]  pc,
    output rvPkg::retireT           retire
);

    rvPkg::ctrlT            ctrl;
    logic [rvPkg::xlen-1:0] imm;
    logic [rvPkg::xlen-1:0] dnpc;
    logic [rvPkg::xlen-1:0] wbData;
    logic [rvPkg::xlen-1:0] storeAddr;
    logic [rvPkg::xlen-1:0] storeData;

    instDecode u_instDecode (.inst(inst), .ctrl(ctrl), .imm(imm));

    exeUnit u_exeUnit (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .pc(pc), .imm(imm),
        .dnpc(dnpc), .wbData(wbData), .storeAddr(storeAddr), .storeData(storeData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= rvPkg::resetPc;
        end else begin
            pc <= dnpc;                                          // one instruction per edge.
        end
    end

    // describes the instruction that commits at the coming edge.
    always_comb begin
        retire.valid   = rstN;                                   // writes are gated the same way.
        retire.pc      = pc;
        retire.rdWen   = ctrl.regWen && (ctrl.rd != '0);
        retire.rd      = ctrl.rd;
        retire.rdData  = wbData;
        retire.memWen  = (ctrl.memOp == rvPkg::memSd) || (ctrl.memOp == rvPkg::memSw) ||
                         (ctrl.memOp == rvPkg::memSb);
        retire.memAddr = storeAddr;
        retire.memData = storeData;
    end

endmodule

// File: tb_rvCore.sv
// Testbench for rvCore: runs a random program and checks every retired instruction against a model.
`timescale 1ns/100ps

module tb_rvCore;

    localparam int resetCycles = 4;
    localparam int numChecks   = 2000;
    localparam int cycleLimit  = resetCycles + numChecks + 50;

    logic                   clk;
    logic                   rstN;
    logic [31:0]            inst;
    logic [rvPkg::xlen-1:0] pc;
    rvPkg::retireT          retire;

    logic [31:0]            progMem [256];
    logic [rvPkg::xlen-1:0] mRegs [32];
    logic [rvPkg::xlen-1:0] mMem [256];
    logic [rvPkg::xlen-1:0] mPc;
    int unsigned            lcgState = 41;
    int                     cycleCount = 0;

    logic [2:0] brF3 [6]    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] ldF3 [5]    = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6};
    logic [2:0] stF3 [3]    = '{3'd0, 3'd2, 3'd3};
    logic [6:0] badOps [6]  = '{7'h0b, 7'h0f, 7'h1b, 7'h2b, 7'h3b, 7'h73};   // not rv64i subset.

    rvCore i_rvCore (.clk(clk), .rstN(rstN), .inst(inst), .pc(pc), .retire(retire));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // random program
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {8'h00, lcgState[31:8]};                          // low lcg bits are weak.
    endfunction

    task automatic buildProgram();
        logic [31:0] k, r, v, w;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        for (int i = 0; i < 256; i++) begin
            k     = nextRand();
            r     = nextRand();
            v     = nextRand();
            rd    = {2'b00, r[2:0]};                             // x0..x7, so operands repeat.
            rs1   = {2'b00, r[5:3]};
            rs2   = {2'b00, r[8:6]};
            f3    = r[11:9];
            imm12 = v[11:0];
            f7    = ((f3 == 3'd0 || f3 == 3'd5) && v[0]) ? 7'h20 : 7'h00;
            case (k[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    if (f3 == 3'd1)
                        imm12 = {6'b000000, v[5:0]};
                    else if (f3 == 3'd5)
                        imm12 = {v[12] ? 6'b010000 : 6'b000000, v[5:0]};
                    w = {imm12, rs1, f3, rd, 7'h13};
                end
                4'd4, 4'd5: w = {f7, rs2, rs1, f3, rd, 7'h33};
                4'd6:  w = {v[19:0], rd, 7'h37};                 // upper bit makes big negatives.
                4'd7:  w = {v[19:0], rd, 7'h17};
                4'd8, 4'd9: begin
                    f3 = brF3[int'(r[15:12]) % 6];
                    w  = {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'h63};
                end
                4'd10: w = {v[20], v[10:1], v[11], v[19:12], rd, 7'h6f};
                4'd11: w = {imm12, rs1, 3'b000, rd, 7'h67};
                4'd12: begin
                    imm12 = v[11:0] & 12'h83f;                   // few doublewords, both signs.
                    f3    = stF3[int'(r[15:12]) % 3];
                    w     = {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], 7'h23};
                end
                4'd13, 4'd14: begin
                    imm12 = v[11:0] & 12'h83f;
                    f3    = ldF3[int'(r[15:12]) % 5];
                    w     = {imm12, 5'd0, f3, rd, 7'h03};
                end
                default: w = {r[23:0], v[0], badOps[int'(v[10:8]) % 6]};
            endcase
            progMem[i] = w;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
        logic signed [63:0] t;
        t = v << (64 - bits);
        return t >>> (64 - bits);
    endfunction

    function automatic logic [63:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'd0, $signed(a) < $signed(b)};
            3'd3:    return {63'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic resetModel();
        for (int i = 0; i < 256; i++) begin
            mMem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        mPc = '0;
    endtask

    // executes the instruction at mPc and returns what the core should retire.
    task automatic stepModel(output rvPkg::retireT r);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [63:0] a, b, iImm, sImm, bImm, uImm, jImm, addr, dw, val, npc;
        logic        wr, taken;
        w    = progMem[mPc[9:2]];
        f3   = w[14:12];
        rd   = w[11:7];
        a    = mRegs[w[19:15]];
        b    = mRegs[w[24:20]];
        iImm = sext(64'(w[31:20]), 12);
        sImm = sext(64'({w[31:25], w[11:7]}), 12);
        bImm = sext(64'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
        uImm = sext(64'({w[31:12], 12'h000}), 32);
        jImm = sext(64'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
        r       = '0;
        r.valid = 1'b1;
        r.pc    = mPc;
        npc     = mPc + 64'd4;
        wr      = 1'b0;
        val     = '0;
        addr    = a + iImm;
        dw      = mMem[addr[10:3]];
        case (w[6:0])
            7'h37: {wr, val} = {1'b1, uImm};
            7'h17: {wr, val} = {1'b1, mPc + uImm};
            7'h6f: begin
                {wr, val} = {1'b1, mPc + 64'd4};
                npc = (mPc + jImm) & ~64'd1;
            end
            7'h67: begin
                {wr, val} = {1'b1, mPc + 64'd4};
                npc = (a + iImm) & ~64'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    npc = mPc + bImm;
            end
            7'h03: begin
                wr = 1'b1;
                case (f3)
                    3'd3:    val = dw;
                    3'd2:    val = sext(64'(dw[{addr[2], 5'b00000} +: 32]), 32);
                    3'd6:    val = 64'(dw[{addr[2], 5'b00000} +: 32]);
                    3'd0:    val = sext(64'(dw[{addr[2:0], 3'b000} +: 8]), 8);
                    default: val = 64'(dw[{addr[2:0], 3'b000} +: 8]);
                endcase
            end
            7'h23: begin
                addr      = a + sImm;
                r.memWen  = 1'b1;
                r.memAddr = addr;
                r.memData = b;                                   // whole rs2, lane picked by size.
                case (f3)
                    3'd3:    mMem[addr[10:3]] = b;
                    3'd2:    mMem[addr[10:3]][{addr[2], 5'b00000} +: 32] = b[31:0];
                    default: mMem[addr[10:3]][{addr[2:0], 3'b000} +: 8] = b[7:0];
                endcase
            end
            7'h13: {wr, val} = {1'b1, aluModel(f3, f3 == 3'd5 && w[30], a, iImm)};
            7'h33: {wr, val} = {1'b1, aluModel(f3, w[30], a, b)};
            default: ;                                           // unknown word, plain pc + 4.
        endcase
        if (wr && rd != 5'd0) begin
            r.rdWen   = 1'b1;
            r.rd      = rd;
            r.rdData  = val;
            mRegs[rd] = val;
        end
        mPc = npc;
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic failRun(input string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    // fields behind a low enable carry no meaning.
    function automatic rvPkg::retireT maskIdle(input rvPkg::retireT r);
        rvPkg::retireT m;
        m = r;
        if (!m.rdWen) begin
            m.rd     = '0;
            m.rdData = '0;
        end
        if (!m.memWen) begin
            m.memAddr = '0;
            m.memData = '0;
        end
        return m;
    endfunction

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %s expected %b actual %b", name, expVal, actVal);
            failRun("bit mismatch");
        end
    endtask

    task automatic checkWord(input string name, input logic [rvPkg::xlen-1:0] expVal,
                             input logic [rvPkg::xlen-1:0] actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
            failRun("word mismatch");
        end
    endtask

    task automatic checkRetire(input string name, input rvPkg::retireT expVal,
                               input rvPkg::retireT actVal);
        if (maskIdle(actVal) !== maskIdle(expVal)) begin
            $display("[FAIL] %s expected %h actual %h", name, maskIdle(expVal),
                     maskIdle(actVal));
            failRun("retire record mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("core stopped retiring, %0d cycles passed without %0d checked instructions",
                     cycleLimit, numChecks);
            failRun("timeout");
        end
    end

    initial begin
        rvPkg::retireT          expRetire;
        logic [rvPkg::xlen-1:0] expPc;
        rstN = 1'b0;
        inst = '0;
        buildProgram();
        resetModel();
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            inst = progMem[pc[9:2]];
            checkBit("reset valid", 1'b0, retire.valid);
        end
        rstN = 1'b1;
        for (int n = 0; n < numChecks; n++) begin
            @(negedge clk);                                      // retire settled mid-cycle.
            expPc = mPc;
            stepModel(expRetire);
            checkWord($sformatf("pc #%0d", n), expPc, pc);
            checkRetire($sformatf("retire #%0d inst %h", n, inst), expRetire, retire);
            @(posedge clk);
            #1;
            inst = progMem[pc[9:2]];
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: rvCore.f
rvPkg.sv
alu.sv
regFile.sv
dataMem.sv
nextPc.sv
exeUnit.sv
instDecode.sv
rvCore.sv
tb_rvCore.sv

// File: run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rvCore -f rvCore.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
